//--- bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 4;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release 1 ns after the last reset edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tinyrv1_proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tinyrv1_params.svh"

module tinyrv1_proc_tb;

  localparam int PROG_LEN       = 60;
  localparam int LAST_CSRW      = PROG_LEN - 2;
  localparam int LOOP_SLOT      = PROG_LEN - 1;
  localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 20;

  // Instruction kinds of the generated program
  localparam int K_NONE = 0;
  localparam int K_ADD  = 1;
  localparam int K_ADDI = 2;
  localparam int K_MUL  = 3;
  localparam int K_LW   = 4;
  localparam int K_SW   = 5;
  localparam int K_JAL  = 6;
  localparam int K_JR   = 7;
  localparam int K_BNE  = 8;
  localparam int K_CSRR = 9;
  localparam int K_CSRW = 10;

  logic                  clk;
  logic                  rst_n;
  tinyrv1_pkg::mem_req_t imem_req;
  logic [`XLEN-1:0]      imem_resp;
  tinyrv1_pkg::mem_req_t dmem_req;
  logic [`XLEN-1:0]      dmem_resp;
  tinyrv1_pkg::csr_io_t  csr_in;
  logic [`XLEN-1:0]      out0;
  logic [`XLEN-1:0]      out1;
  logic [`XLEN-1:0]      out2;
  logic                  out0_en;
  logic                  out1_en;
  logic                  out2_en;
  logic [2:0]            out_en;

  integer seed;
  int     edges    = 0;
  int     cycles   = 0;
  int     csr_seen = 0;
  int     st_seen  = 0;

  // Program fields, one entry per instruction slot
  int          p_kind [64];
  logic [4:0]  p_rd   [64];
  logic [4:0]  p_rs1  [64];
  logic [4:0]  p_rs2  [64];
  logic [11:0] p_imm  [64];
  int          p_tgt  [64];

  logic [`XLEN-1:0] imem       [64];
  logic [`XLEN-1:0] dmem       [128];
  logic [`XLEN-1:0] model_rf   [32];
  logic [`XLEN-1:0] model_dmem [128];
  logic [`XLEN-1:0] csr_vals   [3];
  logic [`XLEN-1:0] out_last   [3];

  int               exp_csr_idx [$];
  logic [`XLEN-1:0] exp_csr_val [$];
  logic [`XLEN-1:0] exp_st_addr [$];
  logic [`XLEN-1:0] exp_st_data [$];

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  tinyrv1_proc uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_req  (imem_req),
    .imem_resp (imem_resp),
    .dmem_req  (dmem_req),
    .dmem_resp (dmem_resp),
    .csr_in    (csr_in),
    .out0      (out0),
    .out1      (out1),
    .out2      (out2),
    .out0_en   (out0_en),
    .out1_en   (out1_en),
    .out2_en   (out2_en)
  );

  assign out_en = {out2_en, out1_en, out0_en};

  task automatic end_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  //============================================================
  // Program generation
  //============================================================

  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'(1 + pick(7));
  endfunction

  // Word offset inside the data region
  function automatic logic [11:0] data_off();
    return 12'h100 + 12'(4 * pick(32));
  endfunction

  // Forward target that never lands on a JR, so its ADDI always runs
  function automatic int fwd_target(input int first);
    int t;
    t = first + int'(pick(5));
    if (t > LAST_CSRW) begin
      t = LAST_CSRW;
    end
    while (p_kind[t] == K_JR) begin
      t++;
    end
    return t;
  endfunction

  function automatic logic [31:0] encode(input int i);
    logic [11:0] im;
    logic [20:0] off;
    im  = p_imm[i];
    off = 21'((p_tgt[i] - i) * 4);
    case (p_kind[i])
      K_ADD:  return {7'b0000000, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], 7'b0110011};
      K_ADDI: return {im, p_rs1[i], 3'b000, p_rd[i], 7'b0010011};
      K_MUL:  return {7'b0000001, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], 7'b0110011};
      K_LW:   return {im, 5'd0, 3'b010, p_rd[i], 7'b0000011};
      K_SW:   return {im[11:5], p_rs2[i], 5'd0, 3'b010, im[4:0], 7'b0100011};
      K_JAL:  return {off[20], off[10:1], off[11], off[19:12], p_rd[i], 7'b1101111};
      K_JR:   return {12'd0, p_rs1[i], 3'b000, 5'd0, 7'b1100111};
      K_BNE:  return {off[12], off[10:5], p_rs2[i], p_rs1[i], 3'b001,
                      off[4:1], off[11], 7'b1100011};
      K_CSRR: return {`CSR_IN0 + im, 5'd0, 3'b010, p_rd[i], 7'b1110011};
      K_CSRW: return {`CSR_OUT0 + im, p_rs1[i], 3'b001, 5'd0, 7'b1110011};
      // Unused slots hold ADDI x0 with the slot address
      default: return {12'(i * 4), 5'd0, 3'b000, 5'd0, 7'b0010011};
    endcase
  endfunction

  task automatic build_program();
    int r;
    int i;
    for (int k = 0; k < 64; k++) begin
      p_kind[k] = K_NONE;
      p_rd[k]   = 5'd0;
      p_rs1[k]  = 5'd0;
      p_rs2[k]  = 5'd0;
      p_imm[k]  = 12'd0;
      p_tgt[k]  = 0;
    end
    // Give x1 to x7 known values first
    for (int k = 0; k < 7; k++) begin
      p_kind[k] = K_ADDI;
      p_rd[k]   = 5'(k + 1);
      p_imm[k]  = 12'(pick(4096));
    end
    i = 7;
    while (i < LAST_CSRW) begin
      r        = int'(pick(40));
      p_rd[i]  = pick_reg();
      p_rs1[i] = pick_reg();
      p_rs2[i] = pick_reg();
      p_imm[i] = 12'(pick(4096));
      if (r < 5) begin
        p_kind[i] = K_ADD;
      end else if (r < 10) begin
        p_kind[i] = K_ADDI;
      end else if (r < 13) begin
        p_kind[i] = K_MUL;
      end else if (r < 17) begin
        p_kind[i] = K_LW;
        p_imm[i]  = data_off();
      end else if (r < 20) begin
        p_kind[i] = K_SW;
        p_imm[i]  = data_off();
      end else if (r < 22 && i + 1 < LAST_CSRW) begin
        // Store then load of the same word
        p_kind[i]     = K_SW;
        p_imm[i]      = data_off();
        p_kind[i + 1] = K_LW;
        p_rd[i + 1]   = pick_reg();
        p_imm[i + 1]  = p_imm[i];
        i++;
      end else if (r < 24) begin
        p_kind[i] = K_JAL;
        p_rd[i]   = 5'(pick(8));
      end else if (r < 26 && i + 1 < LAST_CSRW) begin
        // ADDI sets the JR register, address filled in below
        p_kind[i]     = K_ADDI;
        p_rs1[i]      = 5'd0;
        p_kind[i + 1] = K_JR;
        p_rs1[i + 1]  = p_rd[i];
        i++;
      end else if (r < 29) begin
        p_kind[i] = K_BNE;
      end else if (r < 32) begin
        p_kind[i] = K_CSRR;
        p_imm[i]  = 12'(pick(3));
      end else begin
        p_kind[i] = K_CSRW;
        p_imm[i]  = 12'(pick(3));
      end
      i++;
    end
    p_kind[LAST_CSRW] = K_CSRW;
    p_rs1[LAST_CSRW]  = pick_reg();
    p_imm[LAST_CSRW]  = 12'(pick(3));
    p_kind[LOOP_SLOT] = K_JAL;
    p_rd[LOOP_SLOT]   = 5'd0;
    p_tgt[LOOP_SLOT]  = LOOP_SLOT;
    for (int k = 0; k < LOOP_SLOT; k++) begin
      if (p_kind[k] == K_JAL || p_kind[k] == K_BNE) begin
        p_tgt[k] = fwd_target(k + 1);
      end else if (p_kind[k] == K_JR) begin
        p_tgt[k]     = fwd_target(k + 1);
        p_imm[k - 1] = 12'(p_tgt[k] * 4);
      end
    end
    for (int k = 0; k < 64; k++) begin
      imem[k] = encode(k);
    end
  endtask

  //============================================================
  // Reference model
  //============================================================

  task automatic run_model();
    int               pc;
    int               npc;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] wval;
    logic             wen;
    for (int k = 0; k < 32; k++) begin
      model_rf[k] = '0;
    end
    for (int k = 0; k < 128; k++) begin
      model_dmem[k] = dmem[k];
    end
    pc = 0;
    while (pc != LOOP_SLOT) begin
      a    = model_rf[p_rs1[pc]];
      b    = model_rf[p_rs2[pc]];
      wen  = 1'b0;
      wval = '0;
      npc  = pc + 1;
      case (p_kind[pc])
        K_ADD: begin
          wen  = 1'b1;
          wval = a + b;
        end
        K_ADDI: begin
          wen  = 1'b1;
          wval = a + {{20{p_imm[pc][11]}}, p_imm[pc]};
        end
        K_MUL: begin
          wen  = 1'b1;
          wval = a * b;
        end
        K_LW: begin
          wen  = 1'b1;
          wval = model_dmem[p_imm[pc][8:2]];
        end
        K_SW: begin
          model_dmem[p_imm[pc][8:2]] = b;
          exp_st_addr.push_back({20'd0, p_imm[pc]});
          exp_st_data.push_back(b);
        end
        K_JAL: begin
          wen  = 1'b1;
          wval = 32'((pc + 1) * 4);
          npc  = p_tgt[pc];
        end
        K_JR: npc = int'(a >> 2);
        K_BNE: begin
          if (a != b) begin
            npc = p_tgt[pc];
          end
        end
        K_CSRR: begin
          wen  = 1'b1;
          wval = csr_vals[p_imm[pc][1:0]];
        end
        K_CSRW: begin
          exp_csr_idx.push_back(int'(p_imm[pc]));
          exp_csr_val.push_back(a);
        end
        default: npc = pc + 1;
      endcase
      if (wen && p_rd[pc] != 5'd0) begin
        model_rf[p_rd[pc]] = wval;
      end
      pc = npc;
    end
  endtask

  //============================================================
  // Memories and checkers
  //============================================================

  task automatic check_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
    assert (st_seen < exp_st_addr.size()) else begin
      $display("A data memory write happened that the program never makes");
      end_with_failure();
    end
    assert (addr == exp_st_addr[st_seen] && data == exp_st_data[st_seen]) else begin
      $display("Fail at %0t: store %0d wrote %h to %h, expected %h to %h", $time, st_seen,
               data, addr, exp_st_data[st_seen], exp_st_addr[st_seen]);
      end_with_failure();
    end
    st_seen++;
  endtask

  // Outputs without a strobe keep the last value written to them
  task automatic check_held_outputs();
    logic [`XLEN-1:0] vals [3];
    vals[0] = out0;
    vals[1] = out1;
    vals[2] = out2;
    for (int k = 0; k < 3; k++) begin
      assert (out_en[k] || vals[k] == out_last[k]) else begin
        $display("Fail at %0t: out%0d = %h between writes, expected %h",
                 $time, k, vals[k], out_last[k]);
        end_with_failure();
      end
    end
  endtask

  task automatic check_csr_write();
    int               idx;
    logic [`XLEN-1:0] val;
    case (out_en)
      3'b001:  idx = 0;
      3'b010:  idx = 1;
      3'b100:  idx = 2;
      default: idx = -1;
    endcase
    assert (idx >= 0) else begin
      $display("More than one output CSR strobe is high in the same cycle");
      end_with_failure();
    end
    assert (csr_seen < exp_csr_idx.size()) else begin
      $display("An output CSR write came after the last one the program makes");
      end_with_failure();
    end
    val = (idx == 0) ? out0 : (idx == 1) ? out1 : out2;
    assert (idx == exp_csr_idx[csr_seen] && val == exp_csr_val[csr_seen]) else begin
      $display("Fail at %0t: CSR write %0d went to out%0d = %h, expected out%0d = %h",
               $time, csr_seen, idx, val, exp_csr_idx[csr_seen], exp_csr_val[csr_seen]);
      end_with_failure();
    end
    out_last[idx] = exp_csr_val[csr_seen];
    csr_seen++;
  endtask

  // Stores land at the edge, responses follow 1 ns later
  always @(posedge clk) begin
    if (dmem_req.valid && dmem_req.write) begin
      check_store(dmem_req.addr, dmem_req.wdata);
      dmem[dmem_req.addr[8:2]] = dmem_req.wdata;
    end
    #1;
    imem_resp = imem[imem_req.addr[7:2]];
    dmem_resp = dmem[dmem_req.addr[8:2]];
  end

  // First edge only loads the reset state
  always @(posedge clk) begin
    edges++;
    if (!rst_n) begin
      if (edges > 1) begin
        assert (out_en == 3'b000 && !imem_req.valid && !dmem_req.valid) else begin
          $display("A memory request or output CSR strobe was active during reset");
          end_with_failure();
        end
      end
    end else begin
      cycles++;
      assert (!$isunknown(out_en)) else begin
        $display("An output CSR strobe is unknown after reset");
        end_with_failure();
      end
      check_held_outputs();
      if (out_en != 3'b000) begin
        check_csr_write();
      end
    end
  end

  function automatic logic all_seen();
    return csr_seen == exp_csr_idx.size() && st_seen == exp_st_addr.size();
  endfunction

  //============================================================
  // Main sequence
  //============================================================

  initial begin
    imem_resp = '0;
    dmem_resp = '0;
    seed      = 32'h804f_9aba;
    for (int k = 0; k < 3; k++) begin
      csr_vals[k] = $random(seed);
    end
    csr_in.in0 = csr_vals[0];
    csr_in.in1 = csr_vals[1];
    csr_in.in2 = csr_vals[2];
    // Output CSRs come out of reset at zero
    for (int k = 0; k < 3; k++) begin
      out_last[k] = '0;
    end
    // Data words depend on the full byte address
    for (int k = 0; k < 128; k++) begin
      dmem[k] = ((k * 4) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    end
    build_program();
    run_model();
    wait (rst_n === 1'b1);
    while (!all_seen() && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
    end
    if (all_seen()) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("The program did not finish: %0d of %0d output CSR writes after %0d cycles",
               csr_seen, exp_csr_idx.size(), cycles);
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

//--- hdl/proc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tinyrv1_params.svh"

module proc_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tinyrv1_pkg::status_t    status,
  output tinyrv1_pkg::ctrl_sigs_t ctrl
);

  logic [`XLEN-1:0] inst_d;
  logic [`XLEN-1:0] inst_x;
  logic [`XLEN-1:0] inst_m;
  logic [`XLEN-1:0] inst_w;
  logic             val_d;
  logic             val_x;
  logic             val_m;
  logic             val_w;

  logic rs1_en_d;
  logic rs2_en_d;
  logic wen_x;
  logic wen_m;
  logic wen_w;
  logic lw_x;
  logic stall_d;
  logic squash_d;
  logic squash_f;

  logic [1:0] pc_sel_f;
  logic [1:0] op1_byp_d;
  logic [1:0] op2_byp_d;
  logic [1:0] imm_type_d;
  logic       op1_sel_d;
  logic [1:0] op2_sel_d;
  logic [1:0] csrr_sel_d;
  logic       alu_fn_x;
  logic [1:0] result_sel_x;
  logic       dmem_val_m;
  logic       dmem_type_m;
  logic       wb_sel_m;
  logic [2:0] out_en_w;

  function automatic logic writes_rf(input logic [`XLEN-1:0] inst);
    return (inst ==? `ADD) | (inst ==? `ADDI) | (inst ==? `MUL) |
           (inst ==? `LW)  | (inst ==? `JAL)  | (inst ==? `CSRR);
  endfunction

  // Source matches destination, ignoring x0
  function automatic logic dep(input logic [4:0] src, input logic [4:0] dst);
    return (src == dst) && (dst != 5'd0);
  endfunction

  //==========================================================
  // Instruction and valid registers
  //==========================================================

  assign inst_d = status.inst;

  always_ff @(posedge clk) begin
    inst_x <= inst_d;
    inst_m <= inst_x;
    inst_w <= inst_m;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      val_d <= 1'b0;
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      val_d <= ~squash_f | stall_d;
      val_x <= val_d & ~stall_d & ~squash_d;
      val_m <= val_x;
      val_w <= val_m;
    end
  end

  //==========================================================
  // Hazards
  //==========================================================

  assign rs1_en_d = (inst_d ==? `ADD) | (inst_d ==? `ADDI) | (inst_d ==? `MUL) |
                    (inst_d ==? `LW)  | (inst_d ==? `SW)   | (inst_d ==? `JR)  |
                    (inst_d ==? `BNE) | (inst_d ==? `CSRW);
  assign rs2_en_d = (inst_d ==? `ADD) | (inst_d ==? `MUL) |
                    (inst_d ==? `SW)  | (inst_d ==? `BNE);

  assign wen_x = val_x & writes_rf(inst_x);
  assign wen_m = val_m & writes_rf(inst_m);
  assign wen_w = val_w & writes_rf(inst_w);
  assign lw_x  = val_x & (inst_x ==? `LW);

  // Youngest producer wins, load data is not ready in X
  always_comb begin
    op1_byp_d = 2'd0;
    op2_byp_d = 2'd0;
    if (val_d && rs1_en_d) begin
      if (wen_x && !lw_x && dep(inst_d[`RS1], inst_x[`RD])) begin
        op1_byp_d = 2'd1;
      end else if (wen_m && dep(inst_d[`RS1], inst_m[`RD])) begin
        op1_byp_d = 2'd2;
      end else if (wen_w && dep(inst_d[`RS1], inst_w[`RD])) begin
        op1_byp_d = 2'd3;
      end
    end
    if (val_d && rs2_en_d) begin
      if (wen_x && !lw_x && dep(inst_d[`RS2], inst_x[`RD])) begin
        op2_byp_d = 2'd1;
      end else if (wen_m && dep(inst_d[`RS2], inst_m[`RD])) begin
        op2_byp_d = 2'd2;
      end else if (wen_w && dep(inst_d[`RS2], inst_w[`RD])) begin
        op2_byp_d = 2'd3;
      end
    end
  end

  // Load-use stall
  assign stall_d = val_d & lw_x &
                   ((rs1_en_d & dep(inst_d[`RS1], inst_x[`RD])) |
                    (rs2_en_d & dep(inst_d[`RS2], inst_x[`RD])));

  // Taken BNE kills D and F, jumps kill F
  assign squash_d = val_x & (inst_x ==? `BNE) & ~status.eq_x;
  assign squash_f = squash_d | (val_d & ((inst_d ==? `JAL) | (inst_d ==? `JR)));

  //==========================================================
  // Per-stage decode
  //==========================================================

  // Next PC: 0 PC+4, 1 JR, 2 JAL, 3 branch
  always_comb begin
    pc_sel_f = 2'd0;
    if (squash_d) begin
      pc_sel_f = 2'd3;
    end else if (val_d && (inst_d ==? `JR)) begin
      pc_sel_f = 2'd1;
    end else if (val_d && (inst_d ==? `JAL)) begin
      pc_sel_f = 2'd2;
    end
  end

  always_comb begin
    {imm_type_d, op1_sel_d, op2_sel_d} = 5'd0;
    if (val_d) begin
      casez (inst_d)
        //                                         imm   op1   op2
        `ADDI:   {imm_type_d, op1_sel_d, op2_sel_d} = {2'd0, 1'b0, 2'd1};
        `LW:     {imm_type_d, op1_sel_d, op2_sel_d} = {2'd0, 1'b0, 2'd1};
        `SW:     {imm_type_d, op1_sel_d, op2_sel_d} = {2'd1, 1'b0, 2'd1};
        `JAL:    {imm_type_d, op1_sel_d, op2_sel_d} = {2'd2, 1'b1, 2'd2};
        `BNE:    {imm_type_d, op1_sel_d, op2_sel_d} = {2'd3, 1'b0, 2'd0};
        `CSRW:   {imm_type_d, op1_sel_d, op2_sel_d} = {2'd0, 1'b0, 2'd3};
        default: {imm_type_d, op1_sel_d, op2_sel_d} = 5'd0;
      endcase
    end
  end

  always_comb begin
    csrr_sel_d = 2'd0;
    if (val_d && (inst_d ==? `CSRR)) begin
      case (inst_d[`CSR])
        `CSR_IN0: csrr_sel_d = 2'd0;
        `CSR_IN1: csrr_sel_d = 2'd1;
        `CSR_IN2: csrr_sel_d = 2'd2;
        default:  csrr_sel_d = 2'd0;
      endcase
    end
  end

  // Result: 0 ALU, 1 multiplier, 2 CSR
  always_comb begin
    {alu_fn_x, result_sel_x} = 3'd0;
    if (val_x) begin
      casez (inst_x)
        `MUL:    {alu_fn_x, result_sel_x} = {1'b0, 2'd1};
        `BNE:    {alu_fn_x, result_sel_x} = {1'b1, 2'd0};
        `CSRR:   {alu_fn_x, result_sel_x} = {1'b0, 2'd2};
        default: {alu_fn_x, result_sel_x} = 3'd0;
      endcase
    end
  end

  always_comb begin
    {dmem_val_m, dmem_type_m, wb_sel_m} = 3'b000;
    if (val_m) begin
      casez (inst_m)
        `LW:     {dmem_val_m, dmem_type_m, wb_sel_m} = 3'b101;
        `SW:     {dmem_val_m, dmem_type_m, wb_sel_m} = 3'b110;
        default: {dmem_val_m, dmem_type_m, wb_sel_m} = 3'b000;
      endcase
    end
  end

  always_comb begin
    out_en_w = 3'b000;
    if (val_w && (inst_w ==? `CSRW)) begin
      out_en_w[0] = inst_w[`CSR] == `CSR_OUT0;
      out_en_w[1] = inst_w[`CSR] == `CSR_OUT1;
      out_en_w[2] = inst_w[`CSR] == `CSR_OUT2;
    end
  end

  //==========================================================
  // Control bundle
  //==========================================================

  always_comb begin
    ctrl.reg_en_f    = ~stall_d;
    ctrl.pc_sel      = pc_sel_f;
    ctrl.reg_en_d    = ~stall_d;
    ctrl.imm_type    = imm_type_d;
    ctrl.op1_byp_sel = op1_byp_d;
    ctrl.op2_byp_sel = op2_byp_d;
    ctrl.op1_sel     = op1_sel_d;
    ctrl.op2_sel     = op2_sel_d;
    ctrl.csrr_sel    = csrr_sel_d;
    ctrl.alu_fn      = alu_fn_x;
    ctrl.result_sel  = result_sel_x;
    ctrl.dmem_val    = dmem_val_m;
    ctrl.dmem_type   = dmem_type_m;
    ctrl.wb_sel      = wb_sel_m;
    ctrl.rf_wen      = wen_w;
    ctrl.rf_waddr    = wen_w ? inst_w[`RD] : 5'd0;
    ctrl.out0_en     = out_en_w[0];
    ctrl.out1_en     = out_en_w[1];
    ctrl.out2_en     = out_en_w[2];
  end

endmodule

`default_nettype wire

//--- hdl/proc_dpath.sv
`timescale 1ns/1ps
`default_nettype none

`include "tinyrv1_params.svh"

module proc_dpath (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tinyrv1_pkg::ctrl_sigs_t ctrl,
  output tinyrv1_pkg::status_t    status,
  output tinyrv1_pkg::mem_req_t   imem_req,
  input  logic [`XLEN-1:0]        imem_resp,
  output tinyrv1_pkg::mem_req_t   dmem_req,
  input  logic [`XLEN-1:0]        dmem_resp,
  input  tinyrv1_pkg::csr_io_t    csr_in,
  output logic [`XLEN-1:0]        out0,
  output logic [`XLEN-1:0]        out1,
  output logic [`XLEN-1:0]        out2
);

  logic             fetch_on;
  logic [`XLEN-1:0] pc_f;
  logic [`XLEN-1:0] pc_next;

  logic [`XLEN-1:0] inst_d;
  logic [`XLEN-1:0] pc_d;
  logic [`XLEN-1:0] imm_d;
  logic [`XLEN-1:0] rdata1_d;
  logic [`XLEN-1:0] rdata2_d;
  logic [`XLEN-1:0] rs1_d;
  logic [`XLEN-1:0] rs2_d;
  logic [`XLEN-1:0] op1_d;
  logic [`XLEN-1:0] op2_d;
  logic [`XLEN-1:0] targ_d;
  logic [`XLEN-1:0] csr_d;

  logic [`XLEN-1:0] op1_x;
  logic [`XLEN-1:0] op2_x;
  logic [`XLEN-1:0] sd_x;
  logic [`XLEN-1:0] csr_x;
  logic [`XLEN-1:0] targ_x;
  logic [`XLEN-1:0] alu_x;
  logic [`XLEN-1:0] result_x;
  logic             eq_x;

  logic [`XLEN-1:0] result_m;
  logic [`XLEN-1:0] sd_m;
  logic [`XLEN-1:0] wb_m;
  logic [`XLEN-1:0] wb_w;

  logic [2:0]       out_en;
  logic [`XLEN-1:0] out_q [3];

  // Operand source: 0 RF, 1 X, 2 M, 3 W
  function automatic logic [`XLEN-1:0] byp_mux(input logic [1:0]       sel,
                                               input logic [`XLEN-1:0] rf_val,
                                               input logic [`XLEN-1:0] x_val,
                                               input logic [`XLEN-1:0] m_val,
                                               input logic [`XLEN-1:0] w_val);
    case (sel)
      2'd1:    return x_val;
      2'd2:    return m_val;
      2'd3:    return w_val;
      default: return rf_val;
    endcase
  endfunction

  //==========================================================
  // F stage
  //==========================================================

  // Fetch starts the cycle after reset is released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_on <= 1'b0;
      pc_f     <= '0;
    end else begin
      fetch_on <= 1'b1;
      if (ctrl.reg_en_f && fetch_on) begin
        pc_f <= pc_next;
      end
    end
  end

  always_comb begin
    case (ctrl.pc_sel)
      2'd1:    pc_next = rs1_d;
      2'd2:    pc_next = targ_d;
      2'd3:    pc_next = targ_x;
      default: pc_next = pc_f + `XLEN'd4;
    endcase
  end

  assign imem_req = '{valid: fetch_on, write: 1'b0, addr: pc_f, wdata: '0};

  //==========================================================
  // D stage
  //==========================================================

  // Before the first fetch D holds an all-zero word that decodes as nothing
  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) begin
      inst_d <= fetch_on ? imem_resp : '0;
      pc_d   <= pc_f;
    end
  end

  assign status.inst = inst_d;

  proc_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (inst_d[`RS1]),
    .raddr2 (inst_d[`RS2]),
    .rdata1 (rdata1_d),
    .rdata2 (rdata2_d),
    .wen    (ctrl.rf_wen),
    .waddr  (ctrl.rf_waddr),
    .wdata  (wb_w)
  );

  // Immediates: 0 I, 1 S, 2 J, 3 B
  always_comb begin
    case (ctrl.imm_type)
      2'd1: imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      2'd2: imm_d = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
      2'd3: imm_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
      default: imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  assign rs1_d = byp_mux(ctrl.op1_byp_sel, rdata1_d, result_x, wb_m, wb_w);
  assign rs2_d = byp_mux(ctrl.op2_byp_sel, rdata2_d, result_x, wb_m, wb_w);

  assign op1_d = ctrl.op1_sel ? pc_d : rs1_d;

  always_comb begin
    case (ctrl.op2_sel)
      2'd1:    op2_d = imm_d;
      2'd2:    op2_d = `XLEN'd4;
      2'd3:    op2_d = '0;
      default: op2_d = rs2_d;
    endcase
  end

  // JAL target here, branch target carried to X
  assign targ_d = pc_d + imm_d;

  always_comb begin
    case (ctrl.csrr_sel)
      2'd1:    csr_d = csr_in.in1;
      2'd2:    csr_d = csr_in.in2;
      default: csr_d = csr_in.in0;
    endcase
  end

  //==========================================================
  // X stage
  //==========================================================

  always_ff @(posedge clk) begin
    op1_x  <= op1_d;
    op2_x  <= op2_d;
    sd_x   <= rs2_d;
    csr_x  <= csr_d;
    targ_x <= targ_d;
  end

  assign eq_x        = op1_x == op2_x;
  assign status.eq_x = eq_x;
  assign alu_x       = ctrl.alu_fn ? {{(`XLEN-1){1'b0}}, eq_x} : op1_x + op2_x;

  always_comb begin
    case (ctrl.result_sel)
      2'd1:    result_x = op1_x * op2_x;
      2'd2:    result_x = csr_x;
      default: result_x = alu_x;
    endcase
  end

  //==========================================================
  // M and W stages
  //==========================================================

  always_ff @(posedge clk) begin
    result_m <= result_x;
    sd_m     <= sd_x;
    wb_w     <= wb_m;
  end

  assign dmem_req = '{valid: ctrl.dmem_val, write: ctrl.dmem_type,
                      addr: result_m, wdata: sd_m};
  assign wb_m     = ctrl.wb_sel ? dmem_resp : result_m;

  // Output CSRs show the new value during the write cycle
  assign out_en = {ctrl.out2_en, ctrl.out1_en, ctrl.out0_en};

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (!rst_n) begin
        out_q[i] <= '0;
      end else if (out_en[i]) begin
        out_q[i] <= wb_w;
      end
    end
  end

  assign out0 = out_en[0] ? wb_w : out_q[0];
  assign out1 = out_en[1] ? wb_w : out_q[1];
  assign out2 = out_en[2] ? wb_w : out_q[2];

endmodule

`default_nettype wire

//--- hdl/proc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "tinyrv1_params.svh"

module proc_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       raddr1,
  input  logic [4:0]       raddr2,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2,
  input  logic             wen,
  input  logic [4:0]       waddr,
  input  logic [`XLEN-1:0] wdata
);

  logic [`XLEN-1:0] regs [32];

  // No writes while the pipeline is held in reset
  always_ff @(posedge clk) begin
    if (rst_n && wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/tinyrv1_params.svh
`ifndef TINYRV1_PARAMS_SVH
`define TINYRV1_PARAMS_SVH

// Data path width
`define XLEN 32

// Instruction field ranges
`define RS1 19:15
`define RS2 24:20
`define RD  11:7
`define CSR 31:20

//==========================================================
// Instruction match patterns, used with ==? and casez
//==========================================================

`define ADD  32'b0000000_?????_?????_000_?????_0110011
`define ADDI 32'b???????_?????_?????_000_?????_0010011
`define MUL  32'b0000001_?????_?????_000_?????_0110011
`define LW   32'b???????_?????_?????_010_?????_0000011
`define SW   32'b???????_?????_?????_010_?????_0100011
`define JAL  32'b???????_?????_?????_???_?????_1101111
`define JR   32'b0000000_00000_?????_000_00000_1100111
`define BNE  32'b???????_?????_?????_001_?????_1100011
`define CSRR 32'b???????_?????_00000_010_?????_1110011
`define CSRW 32'b???????_?????_?????_001_00000_1110011

// CSR numbers
`define CSR_IN0  12'hfc2
`define CSR_IN1  12'hfc3
`define CSR_IN2  12'hfc4
`define CSR_OUT0 12'h7c2
`define CSR_OUT1 12'h7c3
`define CSR_OUT2 12'h7c4

`endif

//--- hdl/tinyrv1_pkg.sv
`default_nettype none

`include "tinyrv1_params.svh"

package tinyrv1_pkg;

  // Control unit to datapath, grouped by stage
  typedef struct packed {
    // F
    logic       reg_en_f;
    logic [1:0] pc_sel;
    // D
    logic       reg_en_d;
    logic [1:0] imm_type;
    logic [1:0] op1_byp_sel;
    logic [1:0] op2_byp_sel;
    logic       op1_sel;
    logic [1:0] op2_sel;
    logic [1:0] csrr_sel;
    // X
    logic       alu_fn;
    logic [1:0] result_sel;
    // M
    logic       dmem_val;
    logic       dmem_type;
    logic       wb_sel;
    // W
    logic       rf_wen;
    logic [4:0] rf_waddr;
    logic       out0_en;
    logic       out1_en;
    logic       out2_en;
  } ctrl_sigs_t;

  // Datapath to control unit
  typedef struct packed {
    logic [`XLEN-1:0] inst;
    logic             eq_x;
  } status_t;

  // Memory request, answered in the same cycle
  typedef struct packed {
    logic             valid;
    logic             write;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } mem_req_t;

  // Input CSR values
  typedef struct packed {
    logic [`XLEN-1:0] in0;
    logic [`XLEN-1:0] in1;
    logic [`XLEN-1:0] in2;
  } csr_io_t;

endpackage

`default_nettype wire

//--- hdl/tinyrv1_proc.sv
`timescale 1ns/1ps
`default_nettype none

`include "tinyrv1_params.svh"

module tinyrv1_proc (
  input  logic                  clk,
  input  logic                  rst_n,
  output tinyrv1_pkg::mem_req_t imem_req,
  input  logic [`XLEN-1:0]      imem_resp,
  output tinyrv1_pkg::mem_req_t dmem_req,
  input  logic [`XLEN-1:0]      dmem_resp,
  input  tinyrv1_pkg::csr_io_t  csr_in,
  output logic [`XLEN-1:0]      out0,
  output logic [`XLEN-1:0]      out1,
  output logic [`XLEN-1:0]      out2,
  output logic                  out0_en,
  output logic                  out1_en,
  output logic                  out2_en
);

  tinyrv1_pkg::ctrl_sigs_t ctrl;
  tinyrv1_pkg::status_t    status;

  proc_ctrl u_ctrl (
    .clk    (clk),
    .rst_n  (rst_n),
    .status (status),
    .ctrl   (ctrl)
  );

  proc_dpath u_dpath (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .status    (status),
    .imem_req  (imem_req),
    .imem_resp (imem_resp),
    .dmem_req  (dmem_req),
    .dmem_resp (dmem_resp),
    .csr_in    (csr_in),
    .out0      (out0),
    .out1      (out1),
    .out2      (out2)
  );

  // Write strobes come straight from W decode
  assign out0_en = ctrl.out0_en;
  assign out1_en = ctrl.out1_en;
  assign out2_en = ctrl.out2_en;

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/tinyrv1_pkg.sv
hdl/proc_regfile.sv
hdl/proc_ctrl.sv
hdl/proc_dpath.sv
hdl/tinyrv1_proc.sv
bench/clk_gen.sv
bench/tinyrv1_proc_tb.sv
